// File: pe_conv.f
src/pe_conv_pkg.sv
src/pe_cmd_decode.sv
src/pe_row_controller.sv
src/pe_mac_window.sv
src/pe_psum_buffer.sv
src/pe_conv_top.sv
verif/pe_conv_sva.sv
verif/pe_conv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PE convolution testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f pe_conv.f --top-module pe_conv_tb \
    -o pe_conv_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/pe_conv_sim > sim.log 2>&1
cat sim.log

grep -q "=== PASS ===" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: verif/pe_conv_stimulus.txt
# B bias | K k0 k1 k2 | R last_channel p0..p7 | E twelve expected results of a map
# Rows alternate between the mid row and the last row of a map
B 5
K 1 2 3
R 1 1 2 3 4 5 6 7 8
R 1 -1 2 -3 4 -5 6 -7 8
E 19 25 31 37 43 49 -1 13 -5 17 -9 21
B -3
K 1 0 0
R 0 1 2 3 4 5 6 7 8
R 0 10 20 30 40 50 60 70 80
K 0 1 0
R 0 1 2 3 4 5 6 7 8
R 0 10 20 30 40 50 60 70 80
K 0 0 2
R 1 1 2 3 4 5 6 7 8
R 1 10 20 30 40 50 60 70 80
E 6 10 14 18 22 26 87 127 167 207 247 287
R 1 1 2 3 4 5 6 7 8
R 1 10 10 10 10 10 10 10 10
E 3 5 7 9 11 13 17 17 17 17 17 17

// File: verif/pe_conv_tb.sv
`default_nettype none

module pe_conv_tb;
    import pe_conv_pkg::*;

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    cmd_t      cmd;
    logic      pixel_valid;
    pixel_t    pixel;
    logic      pe_ready;
    logic      pe_idle;
    axis_out_t m_axis;

    string lines[$];
    int    beat_data[$];
    int    beat_last[$];
    int    cycle_cnt = 0;
    int    cycle_limit = 0;
    int    error_cnt = 0;
    int    model_psum[BUF_DEPTH];
    int    model_out[BUF_DEPTH];
    logic  model_first = 1'b1;
    int    kern[KERNEL_SIZE];
    int    bias_val = 0;
    int    row_idx = 0;

    pe_conv_top pe_conv_top_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pe_ready    (pe_ready),
        .pe_idle     (pe_idle),
        .m_axis      (m_axis)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    // Output beats sampled away from the rising edge
    always @(negedge clk) begin
        if (!reset && m_axis.tvalid) begin
            beat_data.push_back(int'($signed(m_axis.tdata)));
            beat_last.push_back(int'(m_axis.tlast));
        end
    end

    task automatic check(input string what, input int got, input int exp);
        if (got !== exp) begin
            error_cnt++;
            $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic send_cmd(input cmd_op_e op, input logic last, input logic [23:0] data);
        cmd_valid = 1'b1;
        cmd.op = op;
        cmd.last_channel = last;
        cmd.payload = data;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd = '0;
    endtask

    task automatic load_kernel(input string line);
        int r;
        int n;
        r = $sscanf(line, "K %d %d %d", kern[0], kern[1], kern[2]);
        check("kernel record fields", r, 3);
        send_cmd(CMD_LOAD_KERNEL, 1'b0, {8'(kern[2]), 8'(kern[1]), 8'(kern[0])});
        n = 1;
        while (!pe_ready) begin
            @(negedge clk);
            n++;
        end
        check("pe_ready delay after kernel load", n, 3);
        @(negedge clk);
        check("pe_ready after its pulse", int'(pe_ready), 0);
    endtask

    task automatic stream_row(input string line);
        int r;
        int last_ch;
        int gap;
        int w;
        int idx;
        int px[ROW_LEN];
        r = $sscanf(line, "R %d %d %d %d %d %d %d %d %d", last_ch,
                    px[0], px[1], px[2], px[3], px[4], px[5], px[6], px[7]);
        check("row record fields", r, 9);
        send_cmd((row_idx == ROWS_PER_MAP - 1) ? CMD_STREAM_LAST_ROW : CMD_STREAM_ROW,
                 last_ch[0], 24'd0);
        while (pe_idle) begin
            @(negedge clk);
        end
        for (int i = 0; i < ROW_LEN; i++) begin
            pixel_valid = 1'b1;
            pixel = pixel_t'(px[i]);
            @(negedge clk);
            pixel_valid = 1'b0;
            gap = int'($urandom % 4);
            repeat (gap) @(negedge clk);
        end
        while (!pe_idle) begin
            @(negedge clk);
        end
        // Reference model of the window sums and channel accumulation
        for (int j = 0; j < OUT_LEN; j++) begin
            w = kern[0] * px[j] + kern[1] * px[j+1] + kern[2] * px[j+2];
            idx = row_idx * OUT_LEN + j;
            model_psum[idx] = model_first ? bias_val + w : model_psum[idx] + w;
        end
        if (row_idx == ROWS_PER_MAP - 1) begin
            if (last_ch != 0) begin
                model_out = model_psum;
            end
            model_first = (last_ch != 0);
            row_idx = 0;
        end else begin
            row_idx++;
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_map(input string line);
        int r;
        int exp[BUF_DEPTH];
        r = $sscanf(line, "E %d %d %d %d %d %d %d %d %d %d %d %d",
                    exp[0], exp[1], exp[2], exp[3], exp[4], exp[5],
                    exp[6], exp[7], exp[8], exp[9], exp[10], exp[11]);
        check("expect record fields", r, BUF_DEPTH);
        check("beats per map", beat_data.size(), BUF_DEPTH);
        for (int i = 0; i < BUF_DEPTH; i++) begin
            check($sformatf("model result %0d", i), model_out[i], exp[i]);
            check($sformatf("tdata of beat %0d", i), beat_data[i], exp[i]);
            check($sformatf("tlast of beat %0d", i), beat_last[i], int'(i == BUF_DEPTH - 1));
        end
        beat_data.delete();
        beat_last.delete();
    endtask

    initial begin
        int    fd;
        int    n;
        int    r;
        string line;
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        pixel_valid = 1'b0;
        pixel = '0;
        void'($urandom(59));

        fd = $fopen("verif/pe_conv_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file verif/pe_conv_stimulus.txt");
            $display("=== FAIL ===");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r > 0 && line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 40 * lines.size() + 100;

        repeat (5) @(negedge clk);
        reset = 1'b0;
        n = 0;
        while (!pe_idle) begin
            @(negedge clk);
            n++;
        end
        check("pe_idle delay after reset", n, 1);
        check("beats after reset", beat_data.size(), 0);

        foreach (lines[i]) begin
            if (lines[i][0] == "B") begin
                r = $sscanf(lines[i], "B %d", bias_val);
                check("bias record fields", r, 1);
                send_cmd(CMD_SET_BIAS, 1'b0, 24'(bias_val));
                @(negedge clk);
            end else if (lines[i][0] == "K") begin
                load_kernel(lines[i]);
            end else if (lines[i][0] == "R") begin
                stream_row(lines[i]);
            end else if (lines[i][0] == "E") begin
                check_map(lines[i]);
            end else begin
                $display("Unknown record in stimulus file: %s", lines[i]);
                $display("=== FAIL ===");
                $fatal(1);
            end
        end

        check("beats left over", beat_data.size(), 0);
        if (error_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/pe_conv_sva.sv
`default_nettype none

module pe_conv_sva (
    input logic                   clk,
    input logic                   reset,
    input pe_conv_pkg::ctrl_t     ctrl,
    input logic                   win_valid,
    input logic                   row_done,
    input logic                   pe_ready,
    input logic                   pe_idle,
    input pe_conv_pkg::axis_out_t m_axis
);

    property ready_not_idle;
        @(posedge clk) disable iff (reset) !(pe_ready && pe_idle);
    endproperty

    // Each MAC window lands in exactly one buffer write
    property psum_write_matches_window;
        @(posedge clk) disable iff (reset) ctrl.wr_psum == win_valid;
    endproperty

    // Final beat comes from the last window of the row
    property last_needs_valid;
        @(posedge clk) disable iff (reset)
            m_axis.tlast |-> m_axis.tvalid && $past(row_done);
    endproperty

    assert property (ready_not_idle)
        else $error("pe_ready and pe_idle high together");
    assert property (psum_write_matches_window)
        else $error("wr_psum and win_valid disagree");
    assert property (last_needs_valid)
        else $error("tlast without tvalid or away from the row end");

endmodule

// Top level sees both the controller outputs and the output stream
bind pe_conv_top pe_conv_sva pe_conv_sva_inst (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .win_valid (win_valid),
    .row_done  (row_done),
    .pe_ready  (pe_ready),
    .pe_idle   (pe_idle),
    .m_axis    (m_axis)
);

`default_nettype wire

// File: src/pe_conv_top.sv
`default_nettype none

module pe_conv_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  pe_conv_pkg::cmd_t      cmd,
    input  logic                   pixel_valid,
    input  pe_conv_pkg::pixel_t    pixel,
    output logic                   pe_ready,
    output logic                   pe_idle,
    output pe_conv_pkg::axis_out_t m_axis
);
    import pe_conv_pkg::*;

    req_t    req;
    acc_t    bias;
    kernel_t kernel;
    ctrl_t   ctrl;
    logic    win_valid;
    acc_t    win_sum;
    logic    row_done;

    pe_cmd_decode pe_cmd_decode_inst (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .req       (req),
        .bias      (bias),
        .kernel    (kernel)
    );

    pe_row_controller pe_row_controller_inst (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .win_valid (win_valid),
        .row_done  (row_done),
        .ctrl      (ctrl),
        .pe_ready  (pe_ready),
        .pe_idle   (pe_idle)
    );

    // Window only takes pixels while a row is in flight
    pe_mac_window pe_mac_window_inst (
        .clk          (clk),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .kernel       (kernel),
        .wr_kernel    (ctrl.wr_kernel),
        .window_clear (ctrl.window_clear),
        .stream_en    (!pe_idle),
        .win_valid    (win_valid),
        .win_sum      (win_sum),
        .row_done     (row_done)
    );

    pe_psum_buffer pe_psum_buffer_inst (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .win_valid (win_valid),
        .win_sum   (win_sum),
        .bias      (bias),
        .m_axis    (m_axis)
    );

endmodule

`default_nettype wire

// File: src/pe_psum_buffer.sv
`default_nettype none

module pe_psum_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  pe_conv_pkg::ctrl_t     ctrl,
    input  logic                   win_valid,
    input  pe_conv_pkg::acc_t      win_sum,
    input  pe_conv_pkg::acc_t      bias,
    output pe_conv_pkg::axis_out_t m_axis
);
    import pe_conv_pkg::*;

    acc_t              mem [BUF_DEPTH];
    logic [ADDR_W-1:0] addr;
    logic              wr_en;
    logic              last_addr;
    acc_t              base;
    acc_t              sum;
    logic              out_valid;
    logic              out_last;
    acc_t              out_data;

    assign wr_en     = ctrl.wr_psum && win_valid;
    assign last_addr = (addr == ADDR_W'(BUF_DEPTH - 1));

    // First channel starts from the bias instead of stale contents
    assign base = ctrl.add_bias ? bias : mem[addr];
    assign sum  = base + win_sum;

    always_ff @(posedge clk) begin
        if (reset) begin
            addr <= '0;
        end else if (ctrl.rst_addr) begin
            addr <= '0;
        end else if (wr_en) begin
            addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= sum;
            out_data  <= sum;
        end
    end

    // Output beat one cycle after an emitting write
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= wr_en && ctrl.emit;
            out_last  <= wr_en && ctrl.emit && last_addr;
        end
    end

    assign m_axis = '{tvalid: out_valid, tlast: out_last, tdata: out_data};

endmodule

`default_nettype wire

// File: src/pe_mac_window.sv
`default_nettype none

module pe_mac_window (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pixel_valid,
    input  pe_conv_pkg::pixel_t  pixel,
    input  pe_conv_pkg::kernel_t kernel,
    input  logic                 wr_kernel,
    input  logic                 window_clear,
    input  logic                 stream_en,
    output logic                 win_valid,
    output pe_conv_pkg::acc_t    win_sum,
    output logic                 row_done
);
    import pe_conv_pkg::*;

    typedef logic [$clog2(ROW_LEN)-1:0] pix_cnt_t;

    kernel_t  kernel_q;
    pixel_t   hist [KERNEL_SIZE-1];
    pixel_t   taps [KERNEL_SIZE];
    pix_cnt_t pix_cnt;
    logic     armed;
    logic     accept;
    acc_t     dot;

    // Armed from window clear until the row's last pixel
    assign accept = pixel_valid && stream_en && armed;

    always_ff @(posedge clk) begin
        if (wr_kernel) begin
            kernel_q <= kernel;
        end
    end

    // Oldest pixel in tap 0, incoming pixel in the last tap
    always_comb begin
        for (int i = 0; i < KERNEL_SIZE - 1; i++) begin
            taps[i] = hist[i];
        end
        taps[KERNEL_SIZE-1] = pixel;
    end

    always_comb begin
        dot = '0;
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            dot = dot + acc_t'(kernel_q[i]) * acc_t'(taps[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            armed     <= 1'b0;
            pix_cnt   <= '0;
            win_valid <= 1'b0;
            row_done  <= 1'b0;
        end else begin
            win_valid <= 1'b0;
            row_done  <= 1'b0;
            if (window_clear) begin
                armed   <= 1'b1;
                pix_cnt <= '0;
            end else if (accept) begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt >= pix_cnt_t'(KERNEL_SIZE - 1)) begin
                    win_valid <= 1'b1;
                end
                if (pix_cnt == pix_cnt_t'(ROW_LEN - 1)) begin
                    row_done <= 1'b1;
                    armed    <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < KERNEL_SIZE - 2; i++) begin
                hist[i] <= hist[i+1];
            end
            hist[KERNEL_SIZE-2] <= pixel;
            win_sum <= dot;
        end
    end

endmodule

`default_nettype wire

// File: src/pe_row_controller.sv
`default_nettype none

module pe_row_controller (
    input  logic               clk,
    input  logic               reset,
    input  pe_conv_pkg::req_t  req,
    input  logic               win_valid,
    input  logic               row_done,
    output pe_conv_pkg::ctrl_t ctrl,
    output logic               pe_ready,
    output logic               pe_idle
);

    typedef enum logic [3:0] {
        S_RESET,
        S_IDLE,
        S_LOAD,
        S_READY,
        S_WAIT_MID,
        S_WRITE_MID,
        S_WAIT_LAST,
        S_WRITE_LAST,
        S_RST_ADDR
    } state_e;

    state_e state;
    state_e state_next;
    logic   first_channel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    // Bias only on the first channel of a map
    always_ff @(posedge clk) begin
        if (reset) begin
            first_channel <= 1'b1;
        end else if (state == S_RST_ADDR) begin
            first_channel <= req.last_channel;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_RESET: state_next = S_IDLE;
            S_IDLE: begin
                if (req.load_kernel) begin
                    state_next = S_LOAD;
                end else if (req.stream_mid_row) begin
                    state_next = S_WAIT_MID;
                end else if (req.stream_last_row) begin
                    state_next = S_WAIT_LAST;
                end
            end
            S_LOAD:  state_next = S_READY;
            S_READY: state_next = S_IDLE;
            S_WAIT_MID, S_WRITE_MID: begin
                if (win_valid) begin
                    state_next = row_done ? S_IDLE : S_WRITE_MID;
                end else begin
                    state_next = S_WAIT_MID;
                end
            end
            S_WAIT_LAST, S_WRITE_LAST: begin
                // Last row hands over to the address reset
                if (win_valid) begin
                    state_next = row_done ? S_RST_ADDR : S_WRITE_LAST;
                end else begin
                    state_next = S_WAIT_LAST;
                end
            end
            S_RST_ADDR: state_next = S_IDLE;
            default:    state_next = S_IDLE;
        endcase
    end

    always_comb begin
        ctrl     = '0;
        pe_ready = 1'b0;
        pe_idle  = 1'b0;
        case (state)
            S_IDLE: begin
                pe_idle = 1'b1;
                ctrl.window_clear = !req.load_kernel
                                    && (req.stream_mid_row || req.stream_last_row);
            end
            S_LOAD:  ctrl.wr_kernel = 1'b1;
            S_READY: pe_ready = 1'b1;
            S_WAIT_MID, S_WRITE_MID, S_WAIT_LAST, S_WRITE_LAST: begin
                ctrl.wr_psum  = win_valid;
                ctrl.add_bias = win_valid && first_channel;
                // Last channel writes also go out on the stream
                ctrl.emit     = win_valid && req.last_channel;
            end
            S_RST_ADDR: ctrl.rst_addr = 1'b1;
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/pe_cmd_decode.sv
`default_nettype none

module pe_cmd_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid,
    input  pe_conv_pkg::cmd_t    cmd,
    output pe_conv_pkg::req_t    req,
    output pe_conv_pkg::acc_t    bias,
    output pe_conv_pkg::kernel_t kernel
);
    import pe_conv_pkg::*;

    logic is_bias;
    logic is_load;
    logic is_mid;
    logic is_last;

    always_comb begin
        is_bias = 1'b0;
        is_load = 1'b0;
        is_mid  = 1'b0;
        is_last = 1'b0;
        if (cmd_valid) begin
            case (cmd.op)
                CMD_SET_BIAS:        is_bias = 1'b1;
                CMD_LOAD_KERNEL:     is_load = 1'b1;
                CMD_STREAM_ROW:      is_mid  = 1'b1;
                CMD_STREAM_LAST_ROW: is_last = 1'b1;
                default: begin
                    // NOP and undefined codes are dropped
                end
            endcase
        end
    end

    // One-cycle request pulses, channel flag kept as a level
    always_ff @(posedge clk) begin
        if (reset) begin
            req <= '0;
        end else begin
            req.load_kernel     <= is_load;
            req.stream_mid_row  <= is_mid;
            req.stream_last_row <= is_last;
            if (is_load || is_mid || is_last) begin
                req.last_channel <= cmd.last_channel;
            end
        end
    end

    // Bias goes straight to the buffer, no controller involvement
    always_ff @(posedge clk) begin
        if (is_bias) begin
            bias <= cmd.payload[ACC_W-1:0];
        end
        if (is_load) begin
            kernel <= cmd.payload;
        end
    end

endmodule

`default_nettype wire

// File: src/pe_conv_pkg.sv
`default_nettype none

package pe_conv_pkg;

    localparam int DATA_W       = 8;
    localparam int ACC_W        = 20;
    localparam int KERNEL_SIZE  = 3;
    localparam int ROW_LEN      = 8;
    localparam int OUT_LEN      = ROW_LEN - KERNEL_SIZE + 1;
    localparam int ROWS_PER_MAP = 2;
    localparam int BUF_DEPTH    = OUT_LEN * ROWS_PER_MAP;
    localparam int ADDR_W       = $clog2(BUF_DEPTH);

    typedef logic signed [DATA_W-1:0] pixel_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Element 0 weighs the oldest pixel of a window
    typedef pixel_t [KERNEL_SIZE-1:0] kernel_t;

    typedef enum logic [2:0] {
        CMD_NOP             = 3'd0,
        CMD_SET_BIAS        = 3'd1,
        CMD_LOAD_KERNEL     = 3'd2,
        CMD_STREAM_ROW      = 3'd3,
        CMD_STREAM_LAST_ROW = 3'd4
    } cmd_op_e;

    // Payload carries a sign-extended bias or a kernel
    typedef struct packed {
        cmd_op_e                       op;
        logic                          last_channel;
        logic [KERNEL_SIZE*DATA_W-1:0] payload;
    } cmd_t;

    typedef struct packed {
        logic load_kernel;
        logic stream_mid_row;
        logic stream_last_row;
        logic last_channel;
    } req_t;

    typedef struct packed {
        logic wr_kernel;
        logic window_clear;
        logic wr_psum;
        logic add_bias;
        logic rst_addr;
        logic emit;
    } ctrl_t;

    typedef struct packed {
        logic tvalid;
        logic tlast;
        acc_t tdata;
    } axis_out_t;

endpackage

`default_nettype wire
